// File: fft2d_top.f
+incdir+logic
logic/fft2d_types_pkg.sv
logic/fft2d_ctrl_pkg.sv
logic/row_dft4.sv
logic/corner_turn.sv
logic/col_dft4.sv
logic/fft2d_top.sv
verif/fft2d_props.sv
verif/fft2d_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fft2d testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f fft2d_top.f --top-module fft2d_tb

# the pass line in the output decides the result
out=$(./obj_dir/Vfft2d_tb) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"
then
  exit 0
fi
exit 1

// File: verif/fft2d_patterns.mem
// columns: input sample (12 bit), expected bin re, expected bin im (16 bit)
// line i of a frame: sample i in row order, bin i in output order (col i/4, k i%4)
// frame 0, impulse of 200 at position 0
0c8 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
000 00c8 0000
// frame 1, constant -50
fce fce0 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
fce 0000 0000
// frame 2, ramp 8 * (4r + n + 1)
008 0440 0000
010 ff00 0100
018 ff00 0000
020 ff00 ff00
028 ffc0 0040
030 0000 0000
038 0000 0000
040 0000 0000
048 ffc0 0000
050 0000 0000
058 0000 0000
060 0000 0000
068 ffc0 ffc0
070 0000 0000
078 0000 0000
080 0000 0000

// File: verif/fft2d_tb.sv
`timescale 1ns/10ps
`include "fft2d_params.svh"

module fft2d_tb
  import fft2d_types_pkg::*;
();

  localparam int NUM_FRAMES = 3;
  localparam int PAT_WORDS  = 3 * NUM_FRAMES * `FFT2D_FRAME;  // sample, re, im per bin
  localparam int WAIT_LIMIT = 200;  // cycles per wait loop

  logic        clk;
  logic        rst_i;
  logic        in_valid;
  sample_t     in_sample;
  logic        out_valid;
  logic        out_last;
  bin_val_t    out_re;
  bin_val_t    out_im;
  logic [15:0] pat_mem [PAT_WORDS];
  bin_val_t    got_re [$];  // bins as they leave the DUT
  bin_val_t    got_im [$];
  logic        got_last [$];
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          last_cnt;     // out_last pulses since reset
  logic        started;      // first sample driven
  logic        early_valid;  // bin seen before any input
  logic        timed_out;

  fft2d_top fft2d_top_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid),
    .in_sample_i (in_sample),
    .out_valid_o (out_valid),
    .out_last_o  (out_last),
    .out_re_o    (out_re),
    .out_im_o    (out_im)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk)
  begin
    if (out_valid)
    begin
      got_re.push_back(out_re);
      got_im.push_back(out_im);
      got_last.push_back(out_last);
      if (!started)
        early_valid = 1'b1;
      if (out_last)
        last_cnt++;
    end
  end

  task automatic compare(input string name, input int exp_val, input int act_val);
    if (exp_val !== act_val)
    begin
      $display("Fail %s expected %0d actual %0d", name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic drive_frame(input int frame, input bit gaps);
    int idle;
    for (int i = 0; i < `FFT2D_FRAME; i++)
    begin
      idle = gaps ? int'($urandom_range(3, 0)) : 0;  // idle cycles before sample
      repeat (idle)
      begin
        @(negedge clk);
        in_valid = 1'b0;
      end
      @(negedge clk);
      in_valid  = 1'b1;
      in_sample = pat_mem[3 * (frame * `FFT2D_FRAME + i)][`FFT2D_IN_W-1:0];
      started   = 1'b1;
    end
  endtask

  task automatic wait_bins(input int count, input string what);
    int t;
    t = 0;
    while (got_re.size() < count && t < WAIT_LIMIT)
    begin
      @(negedge clk);
      t++;
    end
    if (got_re.size() < count)
    begin
      $display("timeout: only %0d of %0d output bins arrived for test %s",
               got_re.size(), count, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_frame(input string name, input int frame);
    int idx;
    for (int i = 0; i < `FFT2D_FRAME; i++)
    begin
      idx = 3 * (frame * `FFT2D_FRAME + i);
      compare($sformatf("%s f%0d bin %0d re", name, frame, i),
              int'(bin_val_t'(pat_mem[idx + 1])), int'(got_re.pop_front()));
      compare($sformatf("%s f%0d bin %0d im", name, frame, i),
              int'(bin_val_t'(pat_mem[idx + 2])), int'(got_im.pop_front()));
      compare($sformatf("%s f%0d bin %0d last", name, frame, i),
              (i == `FFT2D_FRAME - 1) ? 1 : 0, int'(got_last.pop_front()));
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt > errs_before || timed_out)
      fail_cnt++;
    $display("test %s done, %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic run_frames(input string name, input int first, input int count,
                            input bit gaps);
    int errs_before;
    errs_before = err_cnt;
    if (!timed_out)
    begin
      for (int f = first; f < first + count; f++)
        drive_frame(f, gaps);  // frames follow without a break
      @(negedge clk);
      in_valid  = 1'b0;
      in_sample = '0;
      wait_bins(count * `FFT2D_FRAME, name);
      if (!timed_out)
        for (int f = first; f < first + count; f++)
          check_frame(name, f);
    end
    report_test(name, errs_before);
  endtask

  initial
  begin
    int errs_before;
    void'($urandom(32'hcdac));
    $readmemh("verif/fft2d_patterns.mem", pat_mem);
    clk         = 1'b0;
    rst_i       = 1'b1;
    in_valid    = 1'b0;
    in_sample   = '0;
    err_cnt     = 0;
    test_cnt    = 0;
    fail_cnt    = 0;
    last_cnt    = 0;
    started     = 1'b0;
    early_valid = 1'b0;
    timed_out   = 1'b0;
    repeat (16) @(negedge clk);  // 16 reset edges
    rst_i = 1'b0;

    run_frames("impulse", 0, 1, 1'b0);
    run_frames("constant", 1, 1, 1'b0);
    run_frames("ramp_gaps", 2, 1, 1'b1);
    run_frames("back_to_back", 0, NUM_FRAMES, 1'b0);  // both banks busy

    errs_before = err_cnt;
    repeat (64) @(negedge clk);  // quiet window, nothing more may appear
    compare("framing early valid", 0, int'(early_valid));
    compare("framing last count", 6, last_cnt);  // 1 + 1 + 1 + 3 frames
    compare("framing stray bins", 0, got_re.size());
    report_test("framing", errs_before);

    $display("tests %0d, tests with errors %0d, total errors %0d",
             test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: verif/fft2d_props.sv
`timescale 1ns/10ps
`include "fft2d_params.svh"

module fft2d_props
(
  input logic clk,
  input logic rst_i,
  input logic out_valid_i,
  input logic out_last_i
);

  localparam logic [3:0] LAST_BIN = 4'(`FFT2D_FRAME - 1);

  logic [3:0] bin_cnt;  // valid bins seen in current frame

  always_ff @(posedge clk)
  begin
    if (rst_i)
      bin_cnt <= '0;
    else if (out_valid_i)
      bin_cnt <= bin_cnt + 4'd1;  // wraps once per frame
  end

  // sync reset, strobe clear from the first reset edge on
  valid_in_reset: assert property (@(posedge clk) rst_i && $past(rst_i) |-> !out_valid_i)
    else $error("out_valid_o high during reset");

  last_needs_valid: assert property (@(posedge clk) out_last_i |-> out_valid_i)
    else $error("out_last_o high without out_valid_o");

  last_on_16th: assert property (@(posedge clk)
    out_valid_i |-> (out_last_i == (bin_cnt == LAST_BIN)))
    else $error("out_last_o not on the 16th bin of a frame");

endmodule

bind fft2d_top fft2d_props fft2d_props_inst (
  .clk         (clk),
  .rst_i       (rst_i),
  .out_valid_i (out_valid_o),
  .out_last_i  (out_last_o)
);

// File: logic/fft2d_top.sv
`timescale 1ns/10ps

module fft2d_top
  import fft2d_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  sample_t  in_sample_i,
  output logic     out_valid_o,
  output logic     out_last_o,
  output bin_val_t out_re_o,
  output bin_val_t out_im_o
);

  logic     row_valid;  // row bins, one per cycle
  row_val_t row_re;
  row_val_t row_im;
  logic     col_valid;  // transposed stream
  row_val_t col_re;
  row_val_t col_im;

  row_dft4 row_dft4_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_sample_i (in_sample_i),
    .row_valid_o (row_valid),
    .row_re_o    (row_re),
    .row_im_o    (row_im)
  );

  corner_turn corner_turn_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .row_valid_i (row_valid),
    .row_re_i    (row_re),
    .row_im_i    (row_im),
    .col_valid_o (col_valid),
    .col_re_o    (col_re),
    .col_im_o    (col_im)
  );

  col_dft4 col_dft4_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .col_valid_i (col_valid),
    .col_re_i    (col_re),
    .col_im_i    (col_im),
    .out_valid_o (out_valid_o),
    .out_last_o  (out_last_o),
    .out_re_o    (out_re_o),
    .out_im_o    (out_im_o)
  );

endmodule

// File: logic/col_dft4.sv
`timescale 1ns/10ps
`include "fft2d_params.svh"

module col_dft4
  import fft2d_types_pkg::*;
  import fft2d_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     col_valid_i,
  input  row_val_t col_re_i,
  input  row_val_t col_im_i,
  output logic     out_valid_o,
  output logic     out_last_o,
  output bin_val_t out_re_o,
  output bin_val_t out_im_o
);

  localparam pt_idx_t LAST_PT = pt_idx_t'(`FFT2D_N - 1);

  row_val_t    sh_re [3];   // a, b, c of the column in progress
  row_val_t    sh_im [3];
  bin_val_t    x_re [4];    // sign extended butterfly inputs
  bin_val_t    x_im [4];
  bin_val_t    s_re [4];    // a+c, a-c, b+d, b-d
  bin_val_t    s_im [4];
  bin_val_t    res_re [4];  // bins k = 0..3
  bin_val_t    res_im [4];
  pt_idx_t     in_cnt;
  pt_idx_t     col_cnt;     // columns loaded in this frame
  pt_idx_t     emit_cnt;
  emit_phase_t phase;
  logic        last_col;    // emitting column is the frame's 4th
  logic        col_done;

  assign col_done = col_valid_i && (in_cnt == LAST_PT);

  always_comb
  begin
    for (int i = 0; i < 3; i++)
    begin
      x_re[i] = bin_val_t'(sh_re[i]);
      x_im[i] = bin_val_t'(sh_im[i]);
    end
    x_re[3] = bin_val_t'(col_re_i);  // d straight off the port
    x_im[3] = bin_val_t'(col_im_i);
    s_re[0] = x_re[0] + x_re[2];
    s_im[0] = x_im[0] + x_im[2];
    s_re[1] = x_re[0] - x_re[2];
    s_im[1] = x_im[0] - x_im[2];
    s_re[2] = x_re[1] + x_re[3];
    s_im[2] = x_im[1] + x_im[3];
    s_re[3] = x_re[1] - x_re[3];
    s_im[3] = x_im[1] - x_im[3];
  end

  always_ff @(posedge clk)
  begin
    if (col_valid_i)
    begin
      sh_re[2] <= col_re_i;
      sh_im[2] <= col_im_i;
      sh_re[1] <= sh_re[2];
      sh_im[1] <= sh_im[2];
      sh_re[0] <= sh_re[1];
      sh_im[0] <= sh_im[1];
    end
    if (col_done)
    begin
      res_re[0] <= s_re[0] + s_re[2];
      res_im[0] <= s_im[0] + s_im[2];
      res_re[1] <= s_re[1] + s_im[3];  // (a-c) - j(b-d)
      res_im[1] <= s_im[1] - s_re[3];
      res_re[2] <= s_re[0] - s_re[2];
      res_im[2] <= s_im[0] - s_im[2];
      res_re[3] <= s_re[1] - s_im[3];  // (a-c) + j(b-d)
      res_im[3] <= s_im[1] + s_re[3];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      in_cnt   <= '0;
      col_cnt  <= '0;
      emit_cnt <= '0;
      phase    <= PH_COLLECT;
      last_col <= 1'b0;
    end
    else
    begin
      if (col_valid_i)
        in_cnt <= in_cnt + 2'd1;
      if (col_done)
      begin
        col_cnt  <= col_cnt + 2'd1;          // wraps per frame
        last_col <= (col_cnt == LAST_PT);
        phase    <= PH_EMIT;
        emit_cnt <= '0;
      end
      else if (phase == PH_EMIT)
      begin
        emit_cnt <= emit_cnt + 2'd1;
        if (emit_cnt == LAST_PT)
          phase <= PH_COLLECT;
      end
    end
  end

  assign out_valid_o = (phase == PH_EMIT);
  assign out_last_o  = (phase == PH_EMIT) && last_col && (emit_cnt == LAST_PT);
  assign out_re_o    = res_re[emit_cnt];
  assign out_im_o    = res_im[emit_cnt];

endmodule

// File: logic/corner_turn.sv
`timescale 1ns/10ps
`include "fft2d_params.svh"

module corner_turn
  import fft2d_types_pkg::*;
  import fft2d_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     row_valid_i,
  input  row_val_t row_re_i,
  input  row_val_t row_im_i,
  output logic     col_valid_o,
  output row_val_t col_re_o,
  output row_val_t col_im_o
);

  localparam frame_idx_t LAST_IDX = frame_idx_t'(`FFT2D_FRAME - 1);

  row_val_t   mem_re [2][`FFT2D_FRAME];  // two frames of real parts
  row_val_t   mem_im [2][`FFT2D_FRAME];  // and imaginary parts
  bank_t      wr_bank;    // bank taking the incoming frame
  bank_t      rd_bank;
  frame_idx_t wr_idx;     // row-major write address
  frame_idx_t rd_idx;     // column-major read position
  frame_idx_t rd_addr;
  logic       rd_active;
  logic       frame_done;

  assign frame_done = row_valid_i && (wr_idx == LAST_IDX);

  // the other bank always holds the last complete frame
  assign rd_bank = (wr_bank == BANK_A) ? BANK_B : BANK_A;

  // position c*4+r maps to address r*4+c
  assign rd_addr = {rd_idx[1:0], rd_idx[3:2]};

  always_ff @(posedge clk)
  begin
    if (row_valid_i)
    begin
      mem_re[wr_bank][wr_idx] <= row_re_i;
      mem_im[wr_bank][wr_idx] <= row_im_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wr_idx    <= '0;
      wr_bank   <= BANK_A;
      rd_idx    <= '0;
      rd_active <= 1'b0;
    end
    else
    begin
      if (row_valid_i)
        wr_idx <= wr_idx + 4'd1;  // wraps at frame end
      if (frame_done)
      begin
        wr_bank   <= rd_bank;  // swap, full bank becomes read side
        rd_active <= 1'b1;
        rd_idx    <= '0;
      end
      else if (rd_active)
      begin
        rd_idx <= rd_idx + 4'd1;
        if (rd_idx == LAST_IDX)
          rd_active <= 1'b0;  // whole bank drained
      end
    end
  end

  // read-out runs back to back, 16 cycles per frame
  // never overtaken by the next swap, which needs 16 writes
  assign col_valid_o = rd_active;
  assign col_re_o    = mem_re[rd_bank][rd_addr];
  assign col_im_o    = mem_im[rd_bank][rd_addr];

endmodule

// File: logic/row_dft4.sv
`timescale 1ns/10ps
`include "fft2d_params.svh"

module row_dft4
  import fft2d_types_pkg::*;
  import fft2d_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  sample_t  in_sample_i,
  output logic     row_valid_o,
  output row_val_t row_re_o,
  output row_val_t row_im_o
);

  localparam pt_idx_t LAST_PT = pt_idx_t'(`FFT2D_N - 1);

  sample_t     smp_q [3];  // a, b, c of the row in progress
  pt_idx_t     in_cnt;     // samples taken of current row
  emit_phase_t phase;
  pt_idx_t     emit_cnt;   // bin k being driven
  row_val_t    sum_q;      // X0, real only
  row_val_t    alt_q;      // X2, real only
  row_val_t    dre_q;      // a-c, real part of X1 and X3
  row_val_t    dim_q;      // b-d, imag magnitude of X1 and X3
  row_val_t    a;
  row_val_t    b;
  row_val_t    c;
  row_val_t    d;
  logic        row_done;

  assign a = row_val_t'(smp_q[0]);   // sign extend to row width
  assign b = row_val_t'(smp_q[1]);
  assign c = row_val_t'(smp_q[2]);
  assign d = row_val_t'(in_sample_i); // 4th sample taken straight off the port

  assign row_done = in_valid_i && (in_cnt == LAST_PT);

  always_ff @(posedge clk)
  begin
    if (in_valid_i)
    begin
      smp_q[2] <= in_sample_i;  // newest at the top
      smp_q[1] <= smp_q[2];
      smp_q[0] <= smp_q[1];
    end
    if (row_done)
    begin
      sum_q <= a + b + c + d;
      alt_q <= a - b + c - d;
      dre_q <= a - c;
      dim_q <= b - d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      in_cnt   <= '0;
      phase    <= PH_COLLECT;
      emit_cnt <= '0;
    end
    else
    begin
      if (in_valid_i)
        in_cnt <= in_cnt + 2'd1;  // wraps at row end
      if (row_done)
      begin
        phase    <= PH_EMIT;  // X0 goes out next cycle
        emit_cnt <= '0;
      end
      else if (phase == PH_EMIT)
      begin
        emit_cnt <= emit_cnt + 2'd1;
        if (emit_cnt == LAST_PT)
          phase <= PH_COLLECT;
      end
    end
  end

  always_comb
  begin
    row_valid_o = (phase == PH_EMIT);
    case (emit_cnt)
      2'd0:    row_re_o = sum_q;
      2'd2:    row_re_o = alt_q;
      default: row_re_o = dre_q;  // X1 and X3 share the real part
    endcase
    case (emit_cnt)
      2'd1:    row_im_o = -dim_q;  // -j(b-d)
      2'd3:    row_im_o = dim_q;   // +j(b-d)
      default: row_im_o = '0;      // X0, X2 purely real
    endcase
  end

endmodule

// File: logic/fft2d_ctrl_pkg.sv
package fft2d_ctrl_pkg;

  // transform stage: gathering inputs or streaming out bins
  typedef enum logic {PH_COLLECT, PH_EMIT} emit_phase_t;

  // corner-turn ping-pong half
  typedef enum logic {BANK_A, BANK_B} bank_t;

endpackage

// File: logic/fft2d_types_pkg.sv
`include "fft2d_params.svh"

package fft2d_types_pkg;

  // raw real sample from the source
  typedef logic signed [`FFT2D_IN_W-1:0] sample_t;

  // one part (re or im) of a row transform result
  typedef logic signed [`FFT2D_ROW_W-1:0] row_val_t;

  // one part (re or im) of a final 2-D bin
  typedef logic signed [`FFT2D_OUT_W-1:0] bin_val_t;

  // position inside a row or column
  typedef logic [$clog2(`FFT2D_N)-1:0] pt_idx_t;

  // position inside a frame
  typedef logic [$clog2(`FFT2D_FRAME)-1:0] frame_idx_t;

endpackage

// File: logic/fft2d_params.svh
`ifndef FFT2D_PARAMS_SVH
`define FFT2D_PARAMS_SVH

// points per row and per column
`define FFT2D_N      4

// samples per frame, N x N
`define FFT2D_FRAME  16

// input sample width
`define FFT2D_IN_W   12

// row result width, input plus two bits of growth
`define FFT2D_ROW_W  14

// output bin width
`define FFT2D_OUT_W  16

`endif
